/* fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// byte address and line geometry
`define FETCH_ADDR_BITS     32
`define FETCH_OFFSET_BITS   4       // 16 bytes per line
`define FETCH_FIP_BITS      28      // byte address bits 31 to 4
`define FETCH_LINE_BITS     128

// bank geometry
`define FETCH_NUM_BANKS     2       // even and odd lines
`define FETCH_SET_BITS      3
`define FETCH_NUM_SETS      (1 << `FETCH_SET_BITS)

// fip bit 0 picks the bank and the set index sits right above it
`define FETCH_TAG_BITS      (`FETCH_FIP_BITS - `FETCH_SET_BITS - 1)

`endif

/* fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;     // byte address
    typedef logic [`FETCH_FIP_BITS-1:0]  fip_t;      // line address, bit 0 is parity
    typedef logic [`FETCH_LINE_BITS-1:0] line_t;
    typedef logic [`FETCH_TAG_BITS-1:0]  tag_t;
    typedef logic [`FETCH_SET_BITS-1:0]  set_idx_t;

    // control flow target for one bank
    typedef struct packed {
        logic load;
        fip_t target;
    } redirect_t;

    // line written into a bank
    typedef struct packed {
        logic  valid;
        fip_t  fip;
        line_t line;
    } fill_t;

    // what a bank presents for its current fip
    typedef struct packed {
        fip_t  fip;
        logic  hit;
        line_t line;
    } bank_rsp_t;

    //////////////////////////////
    // address slicing

    function automatic fip_t addr_to_fip(addr_t addr);
        return addr[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS];
    endfunction

    function automatic set_idx_t fip_set(fip_t fip);
        return fip[`FETCH_SET_BITS:1];
    endfunction

    function automatic tag_t fip_tag(fip_t fip);
        return fip[`FETCH_FIP_BITS-1:`FETCH_SET_BITS+1];
    endfunction

endpackage

/* cf_arbiter.sv */
`include "fetch_consts.svh"

module cf_arbiter import fetch_pkg::*; (
    input  logic                             init_i,
    input  logic                             resteer_i,
    input  logic                             branch_i,
    input  addr_t                            init_addr_i,
    input  addr_t                            resteer_addr_i,
    input  addr_t                            branch_addr_i,
    input  logic                             next_i,
    input  fill_t                            fill_i,
    output redirect_t [`FETCH_NUM_BANKS-1:0] redir_o,
    output logic                             advance_o,
    output logic      [`FETCH_NUM_BANKS-1:0] fill_valid_o,
    output fill_t                            fill_o
);

    logic  is_cf;       // any control flow strobe this cycle
    addr_t cf_addr;     // winning byte address
    fip_t  line_l;      // winning line
    fip_t  line_l_p1;   // its neighbour in address order

    //////////////////////////////
    // priority select

    assign is_cf = init_i | resteer_i | branch_i;

    always_comb begin
        if (init_i) begin
            cf_addr = init_addr_i;
        end else if (resteer_i) begin
            cf_addr = resteer_addr_i;
        end else begin
            cf_addr = branch_addr_i;    // don't care unless branch_i is up
        end
    end

    assign line_l    = addr_to_fip(cf_addr);
    assign line_l_p1 = line_l + fip_t'(1);   // wraps at the top line

    //////////////////////////////
    // split into even and odd targets

    // the bank matching the parity of L takes L, the other one takes L + 1
    for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : g_place
        assign redir_o[b].load   = is_cf;
        assign redir_o[b].target = (line_l[0] == 1'(b)) ? line_l : line_l_p1;

        // fill goes to the bank of the same parity
        assign fill_valid_o[b] = fill_i.valid && (fill_i.fip[0] == 1'(b));
    end

    // a redirect always wins over a sequential step
    assign advance_o = next_i && !is_cf;

    // payload is shared by both banks
    assign fill_o = fill_i;

endmodule

/* fetch_bank.sv */
`include "fetch_consts.svh"

module fetch_bank import fetch_pkg::*; #(
    parameter int PARITY = 0
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  redirect_t redir_i,
    input  logic      advance_i,
    input  logic      fill_valid_i,
    input  fill_t     fill_i,
    output bank_rsp_t rsp_o
);

    fip_t fip_q;                            // current line of this bank

    logic [`FETCH_NUM_SETS-1:0] valid_q;
    tag_t                       tag_q  [`FETCH_NUM_SETS];
    line_t                      data_q [`FETCH_NUM_SETS];

    logic     wr_en;
    set_idx_t wr_set;
    tag_t     wr_tag;

    set_idx_t rd_set;
    tag_t     rd_tag;

    //////////////////////////////
    // fetch pointer

    // even bank starts at line 0, odd bank at line 1
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fip_q <= fip_t'(PARITY);
        end else if (redir_i.load) begin
            fip_q <= redir_i.target;
        end else if (advance_i) begin
            fip_q <= fip_q + fip_t'(2);     // hop over the other bank's line
        end
    end

    //////////////////////////////
    // fill port

    // the arbiter only routes lines of our own parity here
    assign wr_en  = fill_valid_i;
    assign wr_set = fip_set(fill_i.fip);
    assign wr_tag = fip_tag(fill_i.fip);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_set] <= 1'b1;
        end
    end

    // direct mapped, a new tag simply replaces the old one
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tag_q[wr_set]  <= wr_tag;
            data_q[wr_set] <= fill_i.line;
        end
    end

    //////////////////////////////
    // lookup

    // purely combinational off the fip register
    assign rd_set = fip_set(fip_q);
    assign rd_tag = fip_tag(fip_q);

    assign rsp_o.fip  = fip_q;
    assign rsp_o.hit  = valid_q[rd_set] && (tag_q[rd_set] == rd_tag);
    assign rsp_o.line = data_q[rd_set];

endmodule

/* line_merge.sv */
`include "fetch_consts.svh"

module line_merge import fetch_pkg::*; (
    input  bank_rsp_t [`FETCH_NUM_BANKS-1:0] rsp_i,
    output fip_t                             fetch_fip_o,
    output line_t                            line_lo_o,
    output line_t                            line_hi_o,
    output logic                             fetch_valid_o,
    output logic                             miss_o,
    output fip_t                             miss_fip_o
);

    localparam int EVEN = 0;
    localparam int ODD  = 1;

    logic      odd_first;
    logic      both_hit;
    bank_rsp_t first;       // lower line in fetch order
    bank_rsp_t second;

    //////////////////////////////
    // fetch order

    // the two fips are always neighbours
    // odd leads only when it sits right below the even line
    // which also covers the pair across the wrap to line 0
    assign odd_first = ((rsp_i[ODD].fip + fip_t'(1)) == rsp_i[EVEN].fip);

    assign first  = odd_first ? rsp_i[ODD]  : rsp_i[EVEN];
    assign second = odd_first ? rsp_i[EVEN] : rsp_i[ODD];

    assign fetch_fip_o = first.fip;
    assign line_lo_o   = first.line;
    assign line_hi_o   = second.line;

    //////////////////////////////
    // miss summary

    assign both_hit      = first.hit && second.hit;
    assign fetch_valid_o = both_hit;
    assign miss_o        = !both_hit;

    // lowest missing line, falls back to the first line when nothing misses
    assign miss_fip_o = (first.hit && !second.hit) ? second.fip : first.fip;

endmodule

/* fetch_top.sv */
`include "fetch_consts.svh"

module fetch_top import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // redirect strobes, highest priority first
    input  logic  init_i,
    input  logic  resteer_i,
    input  logic  branch_i,
    input  addr_t init_addr_i,
    input  addr_t resteer_addr_i,
    input  addr_t branch_addr_i,

    input  logic  next_i,           // step both lines forward
    input  fill_t fill_i,

    output fip_t  fetch_fip_o,
    output line_t line_lo_o,
    output line_t line_hi_o,
    output logic  fetch_valid_o,
    output logic  miss_o,
    output fip_t  miss_fip_o
);

    redirect_t [`FETCH_NUM_BANKS-1:0] bank_redir;
    logic                             bank_advance;
    logic      [`FETCH_NUM_BANKS-1:0] bank_fill_valid;
    fill_t                            bank_fill;
    bank_rsp_t [`FETCH_NUM_BANKS-1:0] bank_rsp;

    //////////////////////////////
    // redirect and fill routing

    cf_arbiter i_cf_arbiter (
        .init_i         (init_i),
        .resteer_i      (resteer_i),
        .branch_i       (branch_i),
        .init_addr_i    (init_addr_i),
        .resteer_addr_i (resteer_addr_i),
        .branch_addr_i  (branch_addr_i),
        .next_i         (next_i),
        .fill_i         (fill_i),
        .redir_o        (bank_redir),
        .advance_o      (bank_advance),
        .fill_valid_o   (bank_fill_valid),
        .fill_o         (bank_fill)
    );

    //////////////////////////////
    // even and odd banks

    for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : g_bank
        fetch_bank #(
            .PARITY (b)
        ) i_fetch_bank (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .redir_i      (bank_redir[b]),
            .advance_i    (bank_advance),
            .fill_valid_i (bank_fill_valid[b]),
            .fill_i       (bank_fill),
            .rsp_o        (bank_rsp[b])
        );
    end

    // put the pair in fetch order
    line_merge i_line_merge (
        .rsp_i         (bank_rsp),
        .fetch_fip_o   (fetch_fip_o),
        .line_lo_o     (line_lo_o),
        .line_hi_o     (line_hi_o),
        .fetch_valid_o (fetch_valid_o),
        .miss_o        (miss_o),
        .miss_fip_o    (miss_fip_o)
    );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

/* fetch_tb.sv */
`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int TIMEOUT = 400;       // about 230 cycles of tests plus margin

    logic  clk, rst_n;
    logic  init, resteer, branch, next;
    addr_t init_addr, resteer_addr, branch_addr;
    fill_t fill;
    fip_t  fetch_fip, miss_fip;
    line_t line_lo, line_hi;
    logic  fetch_valid, miss;

    integer seed;
    int     errors = 0;
    int     cycles = 0;

    // reference state
    fip_t  exp_even, exp_odd;
    logic  shadow_valid [`FETCH_NUM_BANKS][`FETCH_NUM_SETS];
    fip_t  shadow_fip   [`FETCH_NUM_BANKS][`FETCH_NUM_SETS];
    line_t shadow_line  [`FETCH_NUM_BANKS][`FETCH_NUM_SETS];

    fip_t  exp_first, exp_second, exp_miss_fip;
    logic  hit_first, hit_second, exp_valid;
    line_t exp_line_first, exp_line_second;

    tb_clk_gen #(.PERIOD(100)) i_tb_clk_gen (.clk_o(clk));

    fetch_top i_fetch_top (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .init_i         (init),
        .resteer_i      (resteer),
        .branch_i       (branch),
        .init_addr_i    (init_addr),
        .resteer_addr_i (resteer_addr),
        .branch_addr_i  (branch_addr),
        .next_i         (next),
        .fill_i         (fill),
        .fetch_fip_o    (fetch_fip),
        .line_lo_o      (line_lo),
        .line_hi_o      (line_hi),
        .fetch_valid_o  (fetch_valid),
        .miss_o         (miss),
        .miss_fip_o     (miss_fip)
    );

    //////////////////////////////
    // reference model

    always @(posedge clk) begin : model
        fip_t tgt;
        if (!rst_n) begin
            exp_even <= '0;
            exp_odd  <= fip_t'(1);
            for (int b = 0; b < `FETCH_NUM_BANKS; b++) begin
                for (int s = 0; s < `FETCH_NUM_SETS; s++) begin
                    shadow_valid[b][s] <= 1'b0;
                end
            end
        end else begin
            if (init || resteer || branch) begin
                if (init) tgt = init_addr[31:4];
                else if (resteer) tgt = resteer_addr[31:4];
                else tgt = branch_addr[31:4];
                if (tgt[0]) begin               // odd target leads
                    exp_odd  <= tgt;
                    exp_even <= tgt + fip_t'(1);
                end else begin
                    exp_even <= tgt;
                    exp_odd  <= tgt + fip_t'(1);
                end
            end else if (next) begin
                exp_even <= exp_even + fip_t'(2);
                exp_odd  <= exp_odd + fip_t'(2);
            end
            if (fill.valid) begin
                shadow_valid[fill.fip[0]][fill.fip[`FETCH_SET_BITS:1]] <= 1'b1;
                shadow_fip[fill.fip[0]][fill.fip[`FETCH_SET_BITS:1]]   <= fill.fip;
                shadow_line[fill.fip[0]][fill.fip[`FETCH_SET_BITS:1]]  <= fill.line;
            end
        end
    end

    // even line leads unless the odd one sits right below it
    always_comb begin
        exp_first  = (exp_odd == exp_even + fip_t'(1)) ? exp_even : exp_odd;
        exp_second = (exp_odd == exp_even + fip_t'(1)) ? exp_odd : exp_even;
        hit_first  = shadow_valid[exp_first[0]][exp_first[`FETCH_SET_BITS:1]] &&
                     shadow_fip[exp_first[0]][exp_first[`FETCH_SET_BITS:1]] == exp_first;
        hit_second = shadow_valid[exp_second[0]][exp_second[`FETCH_SET_BITS:1]] &&
                     shadow_fip[exp_second[0]][exp_second[`FETCH_SET_BITS:1]] == exp_second;
        exp_line_first  = shadow_line[exp_first[0]][exp_first[`FETCH_SET_BITS:1]];
        exp_line_second = shadow_line[exp_second[0]][exp_second[`FETCH_SET_BITS:1]];
        exp_valid    = hit_first && hit_second;
        exp_miss_fip = hit_first ? exp_second : exp_first;
    end

    //////////////////////////////
    // checks, sampled mid cycle

    task automatic value_error(input string name, input logic [127:0] exp, input logic [127:0] act);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
    endtask

    a_fetch_fip: assert property (@(negedge clk) disable iff (!rst_n) fetch_fip == exp_first)
        else value_error("fetch_fip_o", 128'(exp_first), 128'(fetch_fip));
    a_fetch_valid: assert property (@(negedge clk) disable iff (!rst_n) fetch_valid == exp_valid)
        else value_error("fetch_valid_o", 128'(exp_valid), 128'(fetch_valid));
    a_miss: assert property (@(negedge clk) disable iff (!rst_n) miss == !exp_valid)
        else value_error("miss_o", 128'(!exp_valid), 128'(miss));
    a_miss_fip: assert property (@(negedge clk) disable iff (!rst_n)
        exp_valid || miss_fip == exp_miss_fip)
        else value_error("miss_fip_o", 128'(exp_miss_fip), 128'(miss_fip));
    a_line_lo: assert property (@(negedge clk) disable iff (!rst_n)
        !hit_first || line_lo == exp_line_first)
        else value_error("line_lo_o", exp_line_first, line_lo);
    a_line_hi: assert property (@(negedge clk) disable iff (!rst_n)
        !hit_second || line_hi == exp_line_second)
        else value_error("line_hi_o", exp_line_second, line_hi);

    //////////////////////////////
    // stimulus helpers

    task automatic tick();
        @(posedge clk);
        #10;                            // drive just after the edge
    endtask

    function automatic line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic fill_line(input fip_t f, input line_t d);
        fill = '{valid: 1'b1, fip: f, line: d};
        tick();
        fill.valid = 1'b0;
    endtask

    // one strobe, picked by which, onto line l
    task automatic do_redirect(input int which, input fip_t l);
        addr_t a;
        a = {l, 4'($random(seed))};
        case (which)
            0: begin
                init      = 1'b1;
                init_addr = a;
            end
            1: begin
                resteer      = 1'b1;
                resteer_addr = a;
            end
            default: begin
                branch      = 1'b1;
                branch_addr = a;
            end
        endcase
        tick();
        init    = 1'b0;
        resteer = 1'b0;
        branch  = 1'b0;
    endtask

    //////////////////////////////
    // test sequence

    initial begin : stimulus
        fip_t       l;
        logic [2:0] strb;
        logic [1:0] sel;
        seed  = 32'h6a5a_d3f7;
        rst_n = 1'b0;
        {init, resteer, branch, next} = 4'b0;
        init_addr    = '0;
        resteer_addr = '0;
        branch_addr  = '0;
        fill         = '0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        tick();                         // reset state checked here
        tick();

        // priority and split, next_i mixed in
        for (int i = 0; i < 40; i++) begin
            strb = 3'($random(seed));
            {init, resteer, branch} = strb;
            init_addr    = addr_t'($random(seed));
            resteer_addr = addr_t'($random(seed));
            branch_addr  = addr_t'($random(seed));
            next         = 1'($random(seed));
            tick();
            {init, resteer, branch, next} = 4'b0;
        end

        // plain advance with gaps
        for (int i = 0; i < 16; i++) begin
            next = 1'b1;
            tick();
            next = 1'b0;
            if (1'($random(seed))) tick();
        end

        // fill both lines of a pair then fetch it, first pair wraps at the top
        for (int i = 0; i < 12; i++) begin
            l = (i == 0) ? '1 : fip_t'($random(seed));
            fill_line(l, rand_line());
            fill_line(l + fip_t'(1), rand_line());
            do_redirect($unsigned($random(seed)) % 3, l);
            tick();
            next = 1'b1;
            tick();
            next = 1'b0;
        end

        // partial or no fill
        for (int i = 0; i < 12; i++) begin
            l   = fip_t'($random(seed));
            sel = 2'($random(seed));
            if (sel[0]) fill_line(l, rand_line());
            if (sel[1]) fill_line(l + fip_t'(1), rand_line());
            do_redirect($unsigned($random(seed)) % 3, l);
            tick();
        end

        // same set, new tag replaces the old line
        for (int i = 0; i < 6; i++) begin
            l = fip_t'($random(seed));
            fill_line(l, rand_line());
            do_redirect(2, l);
            fill_line(l + fip_t'(16), rand_line());
            do_redirect(1, l);
            do_redirect(0, l + fip_t'(16));
            tick();
        end

        tick();
        $display("errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin : watchdog
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("tests failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
fetch_pkg.sv
cf_arbiter.sv
fetch_bank.sv
line_merge.sv
fetch_top.sv
tb_clk_gen.sv
fetch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
